/* verilog.f */
+incdir+dv
rtl/cpld_pkg.sv
rtl/ifc_bus_decode.sv
rtl/cpld_reg_bank.sv
rtl/cpld_pin_driver.sv
rtl/src3_cpld_top.sv
dv/tb_src3_cpld.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then look for the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_src3_cpld -f verilog.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "build or simulation error"
cat sim.log 2>/dev/null
grep -q "STATUS: PASS" sim.log 2>/dev/null \
    && echo "run_sim: passed" \
    || { echo "run_sim: failed"; exit 1; }

/* dv/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef enum logic [2:0] {
    OP_READ, OP_WRITE, OP_FIELD, OP_VOLT, OP_PINS, OP_WR_NOCS, OP_RD_NOCS
} op_t;

// one row of the stimulus table
typedef struct packed {
    op_t       op;
    reg_addr_t addr;
    reg_data_t data;   // write data or voltage_drop level
    field_in_t io;     // io_in held during the row
    reg_data_t exp;    // read data, io_out or irq
} vec_t;

vec_t        vectors[$];
logic [31:0] lfsr_state = 32'h5ce1_7745;

// expected register state from the register map rules
reg_data_t   shadow_regs [256];
access_cnt_t shadow_cnt;
field_in_t   shadow_io;
logic        shadow_vdrop;

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

task automatic rand_bits(input int n, output reg_data_t v);
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);   // one step per bit
        v = {v[14:0], lfsr_state[0]};
    end
endtask

function automatic reg_data_t field_value(input reg_addr_t a, input field_in_t x);
    case (a)
        ADDR_CMODE:    return {14'd0, x[0], x[2]};
        ADDR_EMS:      return {12'd0, x[7], x[5], x[3], x[1]};
        ADDR_TMP:      return {14'd0, x[6], x[4]};
        ADDR_ACKM:     return {15'd0, x[8]};
        ADDR_SR_ERR:   return {15'd0, x[9]};
        ADDR_PMODE:    return {14'd0, x[12], x[10]};
        ADDR_EN12:     return {15'd0, x[11]};
        ADDR_DOOR2:    return {15'd0, x[15]};
        ADDR_ACPWR:    return {15'd0, x[13]};
        ADDR_RIO_RDY:  return {15'd0, x[14]};
        ADDR_SVON_B:   return {15'd0, x[0]};
        ADDR_REMOTE_B: return {15'd0, x[1]};
        ADDR_EMS6:     return {14'd0, x[4], x[2]};
        ADDR_EMS12:    return {15'd0, x[5]};
        ADDR_HAND_IN:  return {8'd0, x[14:7]};
        default:       return 16'd0;   // unmapped
    endcase
endfunction

function automatic reg_data_t reg_read_value(input reg_addr_t a);
    case (a)
        ADDR_VERSION:  return VERSION;
        ADDR_VIN_FALL: return {15'd0, shadow_vdrop};
        ADDR_CNT0:     return {8'd0, shadow_cnt[7:0]};
        ADDR_CNT1:     return {8'd0, shadow_cnt[15:8]};
        ADDR_CNT2:     return {8'd0, shadow_cnt[23:16]};
        ADDR_CNT3:     return {8'd0, shadow_cnt[31:24]};
        ADDR_TEST16:   return shadow_regs[a];
        default: begin
            if (a >= ADDR_PNDT_SVON && a <= ADDR_CNT_SET) begin
                return shadow_regs[a];
            end
            return field_value(a, shadow_io);
        end
    endcase
endfunction

// connector pins from the expected output registers
function automatic field_in_t io_out_pattern();
    reg_data_t d;
    reg_data_t h;
    reg_data_t c;
    d = shadow_regs[ADDR_EXT_DISP];
    h = shadow_regs[ADDR_HAND_OUT];
    c = shadow_regs[ADDR_CRH];
    return {3'b011, d[0], shadow_regs[ADDR_SELF_SON][0], d[1], shadow_regs[ADDR_SVO][0], d[2],
            shadow_regs[ADDR_RB_ERR][0] & h[7], d[3] & h[6],
            shadow_regs[ADDR_RB_RDY][0] & h[5], d[4] & h[4], c[1] & h[3],
            shadow_regs[ADDR_OVRUN_CLR][0] & h[2], c[0] & h[1],
            shadow_regs[ADDR_PNDT_SVON][0] & h[0]};
endfunction

task automatic push_row(input op_t op, input reg_addr_t a, input reg_data_t d,
                        input reg_data_t e);
    vectors.push_back('{op: op, addr: a, data: d, io: shadow_io, exp: e});
endtask

task automatic read_row(input op_t op, input reg_addr_t a);
    push_row(op, a, 16'd0, reg_read_value(a));
    if (shadow_regs[ADDR_CNT_SET][1:0] == 2'b01) begin
        shadow_cnt++;   // the read counts itself after its data is taken
    end
endtask

task automatic write_row(input reg_addr_t a, input reg_data_t d);
    case (a)
        ADDR_CRH:      shadow_regs[a] = (d[1:0] == 2'b11) ? 16'h0000 : 16'h0003;
        ADDR_EXT_DISP: shadow_regs[a] = d & 16'h001f;
        ADDR_HAND_OUT: shadow_regs[a] = d & 16'h00ff;
        ADDR_CNT_SET:  shadow_regs[a] = d & 16'h0007;
        ADDR_TEST16:   shadow_regs[a] = d;
        default: begin
            if (a >= ADDR_PNDT_SVON && a <= ADDR_ERROR_EN) begin
                shadow_regs[a] = d & 16'h0001;
            end
        end
    endcase
    if (shadow_regs[ADDR_CNT_SET][1]) begin
        shadow_cnt = '0;
    end
    push_row(OP_WRITE, a, d, io_out_pattern());
endtask

task automatic supply_row(input logic level);
    shadow_vdrop = level;
    push_row(OP_VOLT, 8'd0, {15'd0, level}, {15'd0, level});
endtask

// ******************************
// table of all tests
// ******************************
task automatic build_table();
    reg_data_t d;
    shadow_regs = '{default: 16'd0};
    for (int i = ADDR_PNDT_SVON; i <= ADDR_SELF_SON; i++) begin
        shadow_regs[i] = 16'h0001;
    end
    shadow_regs[ADDR_CRH]      = 16'h0003;
    shadow_regs[ADDR_EXT_DISP] = 16'h001f;
    shadow_regs[ADDR_HAND_OUT] = 16'h00ff;
    shadow_regs[ADDR_TEST16]   = 16'h1234;
    shadow_cnt   = '0;
    shadow_io    = '0;
    shadow_vdrop = 1'b0;

    // reset values
    read_row(OP_READ, ADDR_VERSION);
    for (int i = ADDR_PNDT_SVON; i <= ADDR_CNT_SET; i++) begin
        read_row(OP_READ, reg_addr_t'(i));
    end
    read_row(OP_READ, ADDR_TEST16);
    push_row(OP_PINS, 8'd0, 16'd0, 16'h7fff);

    // output registers written then read back
    for (int i = ADDR_PNDT_SVON; i <= ADDR_ERROR_EN; i++) begin
        rand_bits(16, d);
        write_row(reg_addr_t'(i), d);
        read_row(OP_READ, reg_addr_t'(i));
    end
    write_row(ADDR_CRH, 16'h0003);
    read_row(OP_READ, ADDR_CRH);
    write_row(ADDR_CRH, 16'h0002);
    read_row(OP_READ, ADDR_CRH);
    write_row(ADDR_CRH, 16'h0003);
    read_row(OP_READ, ADDR_CRH);
    rand_bits(16, d);
    write_row(ADDR_TEST16, d);
    read_row(OP_READ, ADDR_TEST16);

    // field inputs with two random patterns
    for (int s = 0; s < 2; s++) begin
        rand_bits(16, d);
        shadow_io = d;
        for (int i = ADDR_CMODE; i <= ADDR_HAND_IN; i++) begin
            read_row(OP_FIELD, reg_addr_t'(i));
        end
    end
    read_row(OP_READ, 8'd40);

    // read counter
    write_row(ADDR_CNT_SET, 16'h0001);
    repeat (5) read_row(OP_READ, ADDR_TEST16);
    for (int i = ADDR_CNT0; i <= ADDR_CNT3; i++) begin
        read_row(OP_READ, reg_addr_t'(i));
    end
    read_row(OP_READ, ADDR_CNT0);
    write_row(ADDR_CNT_SET, 16'h0002);
    read_row(OP_READ, ADDR_CNT0);
    read_row(OP_READ, ADDR_CNT_SET);
    write_row(ADDR_CNT_SET, 16'h0000);

    // supply monitor
    supply_row(1'b1);
    read_row(OP_READ, ADDR_VIN_FALL);
    supply_row(1'b0);
    read_row(OP_READ, ADDR_VIN_FALL);

    // chip select high must leave every register unchanged
    rand_bits(16, d);
    push_row(OP_WR_NOCS, ADDR_TEST16, d, io_out_pattern());
    push_row(OP_WR_NOCS, ADDR_HAND_OUT, 16'h0000, io_out_pattern());
    push_row(OP_RD_NOCS, ADDR_TEST16, 16'd0, 16'd0);
    read_row(OP_READ, ADDR_TEST16);
    read_row(OP_READ, ADDR_HAND_OUT);
endtask

`endif

/* dv/tb_src3_cpld.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_src3_cpld import cpld_pkg::*; ();

    localparam reg_data_t VERSION = 16'h5a3c;

    logic      high_cpld_clk = 1'b0;
    logic      rst_n;
    reg_data_t ifc_ad_in;
    reg_data_t ifc_ad_out;
    logic      ifc_ad_oe;
    reg_addr_t ifc_addr;
    logic      ifc_cs;
    logic      ifc_we_b;
    logic      ifc_oe_b;
    logic      ifc_avd;
    logic      irq;
    field_in_t io_in;
    field_in_t io_out;
    logic      voltage_drop;

    int unsigned cycles      = 0;
    int unsigned cycle_limit = 0;
    int          err_count   = 0;
    int          check_count = 0;

    `include "tb_vectors.svh"

    src3_cpld_top #(
        .CPLD_VERSION (VERSION)
    ) i_dut (
        .high_cpld_clk (high_cpld_clk),
        .rst_n         (rst_n),
        .ifc_ad_in     (ifc_ad_in),
        .ifc_ad_out    (ifc_ad_out),
        .ifc_ad_oe     (ifc_ad_oe),
        .ifc_addr      (ifc_addr),
        .ifc_cs        (ifc_cs),
        .ifc_we_b      (ifc_we_b),
        .ifc_oe_b      (ifc_oe_b),
        .ifc_avd       (ifc_avd),
        .irq           (irq),
        .io_in         (io_in),
        .io_out        (io_out),
        .voltage_drop  (voltage_drop)
    );

    always #5 high_cpld_clk = ~high_cpld_clk;   // 100 MHz

    always @(posedge high_cpld_clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, test rows did not finish", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // board pins carry the bits msb-first
    function automatic reg_addr_t addr_to_pins(input reg_addr_t a);
        return {a[0], a[1], a[2], a[3], a[4], a[5], a[6], a[7]};
    endfunction

    function automatic reg_data_t swap_data_bits(input reg_data_t d);
        reg_data_t r;
        for (int i = 0; i < 16; i++) begin
            r[i] = d[15 - i];
        end
        return r;
    endfunction

    task automatic compare_value(input string name, input reg_data_t exp, input reg_data_t got);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // ******************************
    // local bus cycles
    // ******************************
    task automatic bus_address(input reg_addr_t a, input logic cs);
        @(negedge high_cpld_clk);
        ifc_cs   = cs;
        ifc_addr = addr_to_pins(a);
        ifc_avd  = 1'b0;
        repeat (10) @(negedge high_cpld_clk);
        ifc_avd  = 1'b1;
    endtask

    task automatic bus_write(input reg_addr_t a, input reg_data_t d, input logic cs);
        ifc_ad_in = swap_data_bits(d);
        bus_address(a, cs);
        @(negedge high_cpld_clk);
        ifc_we_b = 1'b0;
        repeat (10) @(negedge high_cpld_clk);
        ifc_we_b = 1'b1;
        @(negedge high_cpld_clk);
        ifc_cs = 1'b1;
        repeat (2) @(negedge high_cpld_clk);
    endtask

    task automatic bus_read(input reg_addr_t a, input logic cs, output reg_data_t d,
                            output logic oe);
        bus_address(a, cs);
        @(negedge high_cpld_clk);
        ifc_oe_b = 1'b0;
        repeat (8) @(negedge high_cpld_clk);   // data due within 6
        d  = swap_data_bits(ifc_ad_out);
        oe = ifc_ad_oe;
        repeat (2) @(negedge high_cpld_clk);
        ifc_oe_b = 1'b1;
        @(negedge high_cpld_clk);
        ifc_cs = 1'b1;
        repeat (2) @(negedge high_cpld_clk);
    endtask

    task automatic apply_row(input vec_t v);
        reg_data_t got;
        logic      oe;
        @(negedge high_cpld_clk);
        io_in = v.io;
        case (v.op)
            OP_READ, OP_FIELD: begin
                bus_read(v.addr, 1'b0, got, oe);
                compare_value("ifc_ad_oe", 16'd1, {15'd0, oe});
                compare_value("ifc_ad_out", v.exp, got);
            end
            OP_WRITE, OP_WR_NOCS: begin
                bus_write(v.addr, v.data, (v.op == OP_WRITE) ? 1'b0 : 1'b1);
                compare_value("io_out", v.exp, io_out);
            end
            OP_RD_NOCS: begin
                bus_read(v.addr, 1'b1, got, oe);
                compare_value("ifc_ad_oe", 16'd0, {15'd0, oe});
            end
            OP_VOLT: begin
                voltage_drop = v.data[0];
                repeat (3) @(negedge high_cpld_clk);
                compare_value("irq", v.exp, {15'd0, irq});
            end
            OP_PINS: compare_value("io_out", v.exp, io_out);
            default: begin
                err_count++;
                $display("row holds an unknown operation code %0d", v.op);
            end
        endcase
    endtask

    // ******************************
    // main sequence
    // ******************************
    initial begin
        int   errs_before;
        vec_t v;
        rst_n        = 1'b0;
        ifc_ad_in    = '0;
        ifc_addr     = '0;
        ifc_cs       = 1'b1;
        ifc_we_b     = 1'b1;
        ifc_oe_b     = 1'b1;
        ifc_avd      = 1'b1;
        io_in        = '0;
        voltage_drop = 1'b0;
        build_table();
        cycle_limit = vectors.size() * 40 + 100;
        repeat (5) @(negedge high_cpld_clk);
        rst_n = 1'b1;
        foreach (vectors[i]) begin
            v = vectors[i];
            errs_before = err_count;
            apply_row(v);
            if (err_count == errs_before) begin
                $display("row %0d %s addr %0d ok", i, v.op.name(), v.addr);
            end else begin
                $display("row %0d %s addr %0d mismatch", i, v.op.name(), v.addr);
            end
        end
        $display("rows %0d, checks %0d, errors %0d", vectors.size(), check_count, err_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/src3_cpld_top.sv */
`timescale 1ns/100ps
`default_nettype none

module src3_cpld_top import cpld_pkg::*; #(
    parameter reg_data_t CPLD_VERSION = 16'h2134
) (
    input  logic      high_cpld_clk,
    input  logic      rst_n,
    // local bus, pins msb-first
    input  reg_data_t ifc_ad_in,
    output reg_data_t ifc_ad_out,
    output logic      ifc_ad_oe,
    input  reg_addr_t ifc_addr,
    input  logic      ifc_cs,
    input  logic      ifc_we_b,
    input  logic      ifc_oe_b,
    input  logic      ifc_avd,
    output logic      irq,
    // cabinet field io
    input  field_in_t io_in,
    output field_in_t io_out,
    input  logic      voltage_drop
);

    bus_req_t  bus_req;
    reg_data_t rd_data;
    out_regs_t out_regs;

    ifc_bus_decode i_decode (
        .high_cpld_clk (high_cpld_clk),
        .rst_n         (rst_n),
        .ifc_ad_in     (ifc_ad_in),
        .ifc_addr      (ifc_addr),
        .ifc_cs        (ifc_cs),
        .ifc_we_b      (ifc_we_b),
        .ifc_oe_b      (ifc_oe_b),
        .ifc_avd       (ifc_avd),
        .bus_req       (bus_req)
    );

    cpld_reg_bank #(
        .CPLD_VERSION (CPLD_VERSION)
    ) i_reg_bank (
        .high_cpld_clk (high_cpld_clk),
        .rst_n         (rst_n),
        .bus_req       (bus_req),
        .io_in         (io_in),
        .voltage_drop  (voltage_drop),
        .rd_data       (rd_data),
        .out_regs      (out_regs),
        .irq           (irq)
    );

    cpld_pin_driver i_pin_driver (
        .high_cpld_clk (high_cpld_clk),
        .rst_n         (rst_n),
        .rd_stb        (bus_req.rd_stb),
        .rd_data       (rd_data),
        .out_regs      (out_regs),
        .ifc_cs        (ifc_cs),
        .ifc_oe_b      (ifc_oe_b),
        .ifc_ad_out    (ifc_ad_out),
        .ifc_ad_oe     (ifc_ad_oe),
        .io_out        (io_out)
    );

endmodule

`default_nettype wire

/* rtl/cpld_pin_driver.sv */
`timescale 1ns/100ps
`default_nettype none

module cpld_pin_driver import cpld_pkg::*; (
    input  logic      high_cpld_clk,
    input  logic      rst_n,
    input  logic      rd_stb,
    input  reg_data_t rd_data,
    input  out_regs_t out_regs,
    input  logic      ifc_cs,
    input  logic      ifc_oe_b,
    output reg_data_t ifc_ad_out,
    output logic      ifc_ad_oe,
    output field_in_t io_out
);

    reg_data_t rd_q;   // held for the rest of the read cycle

    always_ff @(posedge high_cpld_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_q <= '0;
        end else if (rd_stb) begin
            rd_q <= rd_data;
        end
    end

    // ******************************
    // local bus data
    // ******************************
    assign ifc_ad_out = rev_data(rd_q);
    assign ifc_ad_oe  = ~ifc_cs & ~ifc_oe_b;   // drive only while host reads

    // ******************************
    // connector pins p13..p01
    // ******************************
    // hand_out gates the shared pins p08..p01
    assign io_out = {IO_OUT_FIXED,
                     out_regs.ext_disp[0],
                     out_regs.self_son,
                     out_regs.ext_disp[1],
                     out_regs.svo,
                     out_regs.ext_disp[2],
                     out_regs.rb_err      & out_regs.hand_out[7],
                     out_regs.ext_disp[3] & out_regs.hand_out[6],
                     out_regs.rb_rdy      & out_regs.hand_out[5],
                     out_regs.ext_disp[4] & out_regs.hand_out[4],
                     out_regs.crh[1]      & out_regs.hand_out[3],
                     out_regs.ovrun_clr   & out_regs.hand_out[2],
                     out_regs.crh[0]      & out_regs.hand_out[1],
                     out_regs.pndt_svon   & out_regs.hand_out[0]};

endmodule

`default_nettype wire

/* rtl/cpld_reg_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module cpld_reg_bank import cpld_pkg::*; #(
    parameter reg_data_t CPLD_VERSION = 16'h2134
) (
    input  logic      high_cpld_clk,
    input  logic      rst_n,
    input  bus_req_t  bus_req,
    input  field_in_t io_in,
    input  logic      voltage_drop,
    output reg_data_t rd_data,
    output out_regs_t out_regs,
    output logic      irq
);

    field_in_t   io_q;      // sampled field inputs
    logic        vin_fall;
    reg_data_t   test16;
    access_cnt_t rd_cnt;

    // ******************************
    // field inputs and supply monitor
    // ******************************
    always_ff @(posedge high_cpld_clk or negedge rst_n) begin
        if (!rst_n) begin
            io_q     <= '0;
            vin_fall <= 1'b0;
        end else begin
            io_q     <= io_in;
            vin_fall <= voltage_drop;
        end
    end

    assign irq = vin_fall;

    // ******************************
    // register writes
    // ******************************
    always_ff @(posedge high_cpld_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_regs <= OUT_REGS_RESET;
            test16   <= TEST16_RESET;
        end else if (bus_req.wr_stb) begin
            case (bus_req.addr)
                ADDR_PNDT_SVON: out_regs.pndt_svon <= bus_req.wdata[0];
                // inverted, 11 closes the loop
                ADDR_CRH:       out_regs.crh <= (bus_req.wdata[1:0] == 2'b11) ? 2'b00 : 2'b11;
                ADDR_OVRUN_CLR: out_regs.ovrun_clr <= bus_req.wdata[0];
                ADDR_EXT_DISP:  out_regs.ext_disp  <= bus_req.wdata[4:0];
                ADDR_RB_RDY:    out_regs.rb_rdy    <= bus_req.wdata[0];
                ADDR_RB_ERR:    out_regs.rb_err    <= bus_req.wdata[0];
                ADDR_SVO:       out_regs.svo       <= bus_req.wdata[0];
                ADDR_SELF_SON:  out_regs.self_son  <= bus_req.wdata[0];
                ADDR_HAND_OUT:  out_regs.hand_out  <= bus_req.wdata[7:0];
                ADDR_ERROR_EN:  out_regs.error_en  <= bus_req.wdata[0];
                ADDR_CNT_SET:   out_regs.cnt_set   <= bus_req.wdata[2:0];
                ADDR_TEST16:    test16             <= bus_req.wdata;
                default: ;   // read-only or unmapped
            endcase
        end
    end

    // read access counter
    always_ff @(posedge high_cpld_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_cnt <= '0;
        end else if (out_regs.cnt_set[1]) begin
            rd_cnt <= '0;
        end else if (bus_req.rd_stb && out_regs.cnt_set[0]) begin
            rd_cnt <= rd_cnt + 1'b1;
        end
    end

    // ******************************
    // read select
    // ******************************
    always_comb begin
        case (bus_req.addr)
            ADDR_VERSION:   rd_data = CPLD_VERSION;
            ADDR_CMODE:     rd_data = reg_data_t'({io_q[0], io_q[2]});
            ADDR_EMS:       rd_data = reg_data_t'({io_q[7], io_q[5], io_q[3], io_q[1]});
            ADDR_TMP:       rd_data = reg_data_t'({io_q[6], io_q[4]});
            ADDR_ACKM:      rd_data = reg_data_t'(io_q[8]);
            ADDR_SR_ERR:    rd_data = reg_data_t'(io_q[9]);
            ADDR_PMODE:     rd_data = reg_data_t'({io_q[12], io_q[10]});
            ADDR_EN12:      rd_data = reg_data_t'(io_q[11]);
            ADDR_DOOR2:     rd_data = reg_data_t'(io_q[15]);
            ADDR_ACPWR:     rd_data = reg_data_t'(io_q[13]);
            ADDR_RIO_RDY:   rd_data = reg_data_t'(io_q[14]);
            ADDR_SVON_B:    rd_data = reg_data_t'(io_q[0]);    // second io board
            ADDR_REMOTE_B:  rd_data = reg_data_t'(io_q[1]);
            ADDR_EMS6:      rd_data = reg_data_t'({io_q[4], io_q[2]});
            ADDR_EMS12:     rd_data = reg_data_t'(io_q[5]);
            ADDR_HAND_IN:   rd_data = reg_data_t'(io_q[14:7]);
            ADDR_PNDT_SVON: rd_data = reg_data_t'(out_regs.pndt_svon);
            ADDR_CRH:       rd_data = reg_data_t'(out_regs.crh);
            ADDR_OVRUN_CLR: rd_data = reg_data_t'(out_regs.ovrun_clr);
            ADDR_EXT_DISP:  rd_data = reg_data_t'(out_regs.ext_disp);
            ADDR_RB_RDY:    rd_data = reg_data_t'(out_regs.rb_rdy);
            ADDR_RB_ERR:    rd_data = reg_data_t'(out_regs.rb_err);
            ADDR_SVO:       rd_data = reg_data_t'(out_regs.svo);
            ADDR_SELF_SON:  rd_data = reg_data_t'(out_regs.self_son);
            ADDR_HAND_OUT:  rd_data = reg_data_t'(out_regs.hand_out);
            ADDR_ERROR_EN:  rd_data = reg_data_t'(out_regs.error_en);
            ADDR_VIN_FALL:  rd_data = reg_data_t'(vin_fall);
            ADDR_CNT_SET:   rd_data = reg_data_t'(out_regs.cnt_set);
            ADDR_CNT0:      rd_data = reg_data_t'(rd_cnt[7:0]);
            ADDR_CNT1:      rd_data = reg_data_t'(rd_cnt[15:8]);
            ADDR_CNT2:      rd_data = reg_data_t'(rd_cnt[23:16]);
            ADDR_CNT3:      rd_data = reg_data_t'(rd_cnt[31:24]);
            ADDR_TEST16:    rd_data = test16;
            default:        rd_data = '0;
        endcase
    end

    // a split crh would open only one safety channel
    a_crh_pair: assert property (@(posedge high_cpld_clk) disable iff (!rst_n)
        (out_regs.crh == 2'b00) || (out_regs.crh == 2'b11));

endmodule

`default_nettype wire

/* rtl/ifc_bus_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module ifc_bus_decode import cpld_pkg::*; (
    input  logic      high_cpld_clk,
    input  logic      rst_n,
    input  reg_data_t ifc_ad_in,
    input  reg_addr_t ifc_addr,
    input  logic      ifc_cs,
    input  logic      ifc_we_b,
    input  logic      ifc_oe_b,
    input  logic      ifc_avd,
    output bus_req_t  bus_req
);

    // bit positions in the control sync chain
    localparam int AVD = 2;
    localparam int OE  = 1;
    localparam int WE  = 0;

    logic [2:0] ctl_s1;
    logic [2:0] ctl_s2;
    logic [2:0] ctl_d;     // edge flop
    logic [2:0] ctl_fall;
    logic       rd_pend;
    logic       rd_stb;
    logic       wr_stb;
    reg_addr_t  addr_q;
    reg_data_t  wdata_q;

    // ******************************
    // synchronizers and edge detect
    // ******************************
    always_ff @(posedge high_cpld_clk or negedge rst_n) begin
        if (!rst_n) begin
            ctl_s1 <= '1;   // strobes idle high
            ctl_s2 <= '1;
            ctl_d  <= '1;
        end else begin
            ctl_s1 <= {ifc_avd, ifc_oe_b, ifc_we_b};
            ctl_s2 <= ctl_s1;
            ctl_d  <= ctl_s2;
        end
    end

    assign ctl_fall = ctl_d & ~ctl_s2;

    // read gets one extra stage to match the old board timing
    always_ff @(posedge high_cpld_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend <= 1'b0;
            rd_stb  <= 1'b0;
            wr_stb  <= 1'b0;
        end else begin
            rd_pend <= ctl_fall[OE];
            rd_stb  <= rd_pend & ~ifc_cs;
            wr_stb  <= ctl_fall[WE] & ~ifc_cs;
        end
    end

    // address on avd fall and data with the write strobe
    always_ff @(posedge high_cpld_clk) begin
        if (ctl_fall[AVD]) begin
            addr_q <= rev_addr(ifc_addr);
        end
        if (ctl_fall[WE] && !ifc_cs) begin
            wdata_q <= rev_data(ifc_ad_in);
        end
    end

    assign bus_req = '{addr: addr_q, wdata: wdata_q, rd_stb: rd_stb, wr_stb: wr_stb};

    // reg bank handles one access per cycle
    a_strobe_excl: assert property (@(posedge high_cpld_clk) disable iff (!rst_n)
        !(rd_stb && wr_stb));

endmodule

`default_nettype wire

/* rtl/cpld_pkg.sv */
`default_nettype none

package cpld_pkg;

    // ******************************
    // widths
    // ******************************
    typedef logic [7:0]  reg_addr_t;
    typedef logic [15:0] reg_data_t;
    typedef logic [31:0] access_cnt_t;
    typedef logic [15:0] field_in_t;

    // one decoded local-bus access
    typedef struct packed {
        reg_addr_t addr;
        reg_data_t wdata;
        logic      rd_stb;
        logic      wr_stb;
    } bus_req_t;

    // host-written output and config registers
    typedef struct packed {
        logic       pndt_svon;
        logic [1:0] crh;          // safety loop, only 00 or 11
        logic       ovrun_clr;
        logic [4:0] ext_disp;     // segment display
        logic       rb_rdy;
        logic       rb_err;
        logic       svo;
        logic       self_son;
        logic [7:0] hand_out;
        logic       error_en;
        logic [2:0] cnt_set;      // [0] count enable, [1] clear
    } out_regs_t;

    // ******************************
    // register map
    // ******************************
    localparam reg_addr_t ADDR_VERSION   = 8'd0;
    localparam reg_addr_t ADDR_CMODE     = 8'd2;
    localparam reg_addr_t ADDR_EMS       = 8'd3;
    localparam reg_addr_t ADDR_TMP       = 8'd4;
    localparam reg_addr_t ADDR_ACKM      = 8'd5;
    localparam reg_addr_t ADDR_SR_ERR    = 8'd6;
    localparam reg_addr_t ADDR_PMODE     = 8'd7;
    localparam reg_addr_t ADDR_EN12      = 8'd8;
    localparam reg_addr_t ADDR_DOOR2     = 8'd9;
    localparam reg_addr_t ADDR_ACPWR     = 8'd10;
    localparam reg_addr_t ADDR_RIO_RDY   = 8'd11;
    localparam reg_addr_t ADDR_SVON_B    = 8'd12;
    localparam reg_addr_t ADDR_REMOTE_B  = 8'd13;
    localparam reg_addr_t ADDR_EMS6      = 8'd14;
    localparam reg_addr_t ADDR_EMS12     = 8'd15;
    localparam reg_addr_t ADDR_HAND_IN   = 8'd17;
    localparam reg_addr_t ADDR_PNDT_SVON = 8'd18;
    localparam reg_addr_t ADDR_CRH       = 8'd19;
    localparam reg_addr_t ADDR_OVRUN_CLR = 8'd20;
    localparam reg_addr_t ADDR_EXT_DISP  = 8'd21;
    localparam reg_addr_t ADDR_RB_RDY    = 8'd22;
    localparam reg_addr_t ADDR_RB_ERR    = 8'd23;
    localparam reg_addr_t ADDR_SVO       = 8'd24;
    localparam reg_addr_t ADDR_SELF_SON  = 8'd25;
    localparam reg_addr_t ADDR_HAND_OUT  = 8'd26;
    localparam reg_addr_t ADDR_ERROR_EN  = 8'd27;
    localparam reg_addr_t ADDR_VIN_FALL  = 8'd28;
    localparam reg_addr_t ADDR_CNT_SET   = 8'd29;
    localparam reg_addr_t ADDR_CNT0      = 8'd30;
    localparam reg_addr_t ADDR_CNT1      = 8'd31;
    localparam reg_addr_t ADDR_CNT2      = 8'd32;
    localparam reg_addr_t ADDR_CNT3      = 8'd33;
    localparam reg_addr_t ADDR_TEST16    = 8'd34;

    // outputs idle high, lamp and counter off
    localparam out_regs_t OUT_REGS_RESET = '{
        pndt_svon: 1'b1, crh: 2'b11, ovrun_clr: 1'b1, ext_disp: 5'h1f,
        rb_rdy: 1'b1, rb_err: 1'b1, svo: 1'b1, self_son: 1'b1,
        hand_out: 8'hff, error_en: 1'b0, cnt_set: 3'd0
    };
    localparam reg_data_t  TEST16_RESET = 16'h1234;
    localparam logic [2:0] IO_OUT_FIXED = 3'b011;

    // pins are wired msb-first on the board
    function automatic reg_addr_t rev_addr(input reg_addr_t a);
        reg_addr_t r;
        for (int i = 0; i < $bits(reg_addr_t); i++) begin
            r[i] = a[$bits(reg_addr_t) - 1 - i];
        end
        return r;
    endfunction

    function automatic reg_data_t rev_data(input reg_data_t d);
        reg_data_t r;
        for (int i = 0; i < $bits(reg_data_t); i++) begin
            r[i] = d[$bits(reg_data_t) - 1 - i];
        end
        return r;
    endfunction

endpackage

`default_nettype wire
